// ==== robSubsystem.f ====
rtl/ctrlFlowPkg.sv
rtl/robTypesPkg.sv
rtl/robPointers.sv
rtl/commitSequencer.sv
rtl/reorderBuffer.sv
rtl/renameStatus.sv
rtl/robSubsystem.sv
tests/robChecker.sv
tests/robSubsystemTb.sv

// ==== tests/robSubsystemTb.sv ====
// ----------------------------
// ROB subsystem testbench
// Clock, reset, step table,
// watchdog and closing report
// ----------------------------
`timescale 1ns/1ps

module robSubsystemTb;

  localparam int chkLook = 1;   // Lookup value and ready
  localparam int chkStat = 2;   // Status busy and tag
  localparam int chkAlloc = 3;  // allocReady and allocTag
  localparam ctrlFlowPkg::instrClass_t clsAlu = ctrlFlowPkg::clsAlu;
  localparam ctrlFlowPkg::instrClass_t clsLoad = ctrlFlowPkg::clsLoad;
  localparam ctrlFlowPkg::instrClass_t clsStore = ctrlFlowPkg::clsStore;
  localparam ctrlFlowPkg::instrClass_t clsBranch = ctrlFlowPkg::clsBranch;
  localparam ctrlFlowPkg::instrClass_t clsJal = ctrlFlowPkg::clsJal;

  typedef struct packed {
    logic [31:0] name;
    logic strobe;
    ctrlFlowPkg::instrClass_t cls;
    logic [4:0] dest;
    logic [31:0] early;
    logic earlyRdy;
    logic cdbV;
    logic [2:0] cdbTag;
    logic [31:0] cdbVal;
    logic brV;            // Always a mispredict
    logic [2:0] brTag;
    logic [31:0] brTarget;
    logic [4:0] probe;    // Lookup tag and source register
    logic [1:0] chk;
    logic [31:0] expA;
    logic [2:0] expB;
  } step_t;

  step_t steps [$];
  step_t cur;
  int stepIdx = 0;
  logic clk = 1'b0;
  logic arstN;
  robTypesPkg::allocReq_t alloc;
  robTypesPkg::cdbMsg_t cdb;
  ctrlFlowPkg::branchRes_t branch;
  robTypesPkg::commitMsg_t commit;
  robTypesPkg::robTag_t allocTag, tagA, tagB;
  logic allocReady, redirectValid, readyA, readyB, busyA, busyB;
  logic [31:0] redirectPc, valueA, valueB;
  int errCount;

  always #20 clk = ~clk;

  assign alloc = '{cls: cur.cls, dest: cur.dest, earlyResult: cur.early,
                   earlyReady: cur.earlyRdy, pc: 32'h100 + 32'(stepIdx * 4)};
  assign cdb = '{valid: cur.cdbV, tag: cur.cdbTag, result: cur.cdbVal};
  assign branch = '{valid: cur.brV, tag: cur.brTag, mispredict: cur.brV, target: cur.brTarget};

  robSubsystem dut_i (
    .clk, .arstN, .alloc, .allocStrobe(cur.strobe), .cdb, .branch,
    .lookupTagA(cur.probe[2:0]), .lookupTagB(cur.probe[2:0]),
    .srcRegA(cur.probe), .srcRegB(cur.probe), .allocReady, .allocTag, .commit,
    .redirectValid, .redirectPc, .valueA, .valueB, .readyA, .readyB,
    .busyA, .busyB, .tagA, .tagB
  );

  robChecker checker_i (
    .clk, .arstN, .alloc, .allocStrobe(cur.strobe), .allocReady, .allocTag, .cdb, .branch,
    .commit, .redirectValid, .redirectPc, .valueA, .valueB, .readyA, .readyB,
    .busyA, .busyB, .tagA, .tagB, .testName(cur.name), .chkKind(cur.chk),
    .expA(cur.expA), .expB(cur.expB), .errCount
  );

  task automatic row(input logic [31:0] name, input logic strobe,
                     input ctrlFlowPkg::instrClass_t cls, input logic [4:0] dest,
                     input logic [31:0] early, input logic earlyRdy,
                     input logic cdbV, input logic [2:0] cdbTag, input logic [31:0] cdbVal,
                     input logic brV, input logic [2:0] brTag, input logic [31:0] brTarget,
                     input logic [4:0] probe, input logic [1:0] chk,
                     input logic [31:0] expA, input logic [2:0] expB);
    steps.push_back('{name, strobe, cls, dest, early, earlyRdy, cdbV, cdbTag, cdbVal,
                      brV, brTag, brTarget, probe, chk, expA, expB});
  endtask

  initial begin
    // In-order commit with out-of-order results and an early-ready JAL
    row("a0",   1, clsAlu,   5, 0, 0,      0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 0);
    row("a1",   1, clsLoad,  6, 0, 0,      0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 1);
    row("jal",  1, clsJal,   5, 'h104, 1,  0, 0, 0,      0, 0, 0, 5, chkStat, 1, 0);
    row("st",   1, clsStore, 0, 0, 0,      0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 3);
    row("cdb1", 0, clsAlu,   0, 0, 0,      1, 1, 'h22,   0, 0, 0, 2, chkLook, 'h104, 1);
    row("cdb0", 0, clsAlu,   0, 0, 0,      1, 0, 'h11,   0, 0, 0, 1, chkLook, 'h22, 1);
    row("cdb3", 0, clsAlu,   0, 0, 0,      1, 3, 'h33,   0, 0, 0, 0, chkLook, 'h11, 1);
    row("cmt1", 0, clsAlu,   0, 0, 0,      0, 0, 0,      0, 0, 0, 5, chkStat, 1, 2);
    row("cmt2", 0, clsAlu,   0, 0, 0,      0, 0, 0,      0, 0, 0, 6, chkStat, 0, 0);
    row("cmt3", 0, clsAlu,   0, 0, 0,      0, 0, 0,      0, 0, 0, 5, chkStat, 0, 0);
    // Fill all 8 entries, tag 5 is a branch
    row("f4",   1, clsAlu,    7, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 4);
    row("f5",   1, clsBranch, 0, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 5);
    row("f6",   1, clsAlu,    7, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 6);
    row("f7",   1, clsAlu,    7, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 7);
    row("f0",   1, clsAlu,    7, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 0);
    row("f1",   1, clsAlu,    7, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 1);
    row("f2",   1, clsAlu,    7, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 2);
    row("f3",   1, clsAlu,    7, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 3);
    row("drp0", 1, clsAlu,    9, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 0, 0);
    row("drp1", 1, clsAlu,    9, 0, 0,     1, 4, 'h44,   0, 0, 0, 7, chkStat, 1, 3);
    row("cmt4", 0, clsAlu,    0, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 0, 0);
    row("resm", 1, clsAlu,    7, 0, 0,     1, 5, 0,      1, 5, 'h800, 0, chkAlloc, 1, 4);
    // Mispredicted branch commits, then one flush cycle
    row("rdir", 0, clsAlu,    0, 0, 0,     0, 0, 0,      0, 0, 0, 7, chkStat, 1, 4);
    row("flsh", 1, clsAlu,    9, 0, 0,     0, 0, 0,      0, 0, 0, 7, chkAlloc, 0, 0);
    row("aftr", 1, clsAlu,    8, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 6);
    row("cdb6", 0, clsAlu,    0, 0, 0,     1, 6, 'h66,   0, 0, 0, 8, chkStat, 1, 6);
    row("cmt6", 0, clsAlu,    0, 0, 0,     0, 0, 0,      0, 0, 0, 6, chkLook, 'h66, 1);
    row("clr8", 0, clsAlu,    0, 0, 0,     0, 0, 0,      0, 0, 0, 8, chkStat, 0, 0);
    row("x0",   1, clsAlu,    0, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkAlloc, 1, 7);
    row("x0st", 0, clsAlu,    0, 0, 0,     0, 0, 0,      0, 0, 0, 0, chkStat, 0, 0);
    cur = '0;
    arstN = 1'b0;
    repeat (16) @(posedge clk);
    #2 arstN = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      @(posedge clk);
      #2;
      stepIdx = i;
      cur = steps[i];
    end
    @(posedge clk);
    #2 cur = '0;
    repeat (2) @(posedge clk);
    $display("Errors: %0d", errCount);
    if (errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Table length plus a margin of 200 cycles
  initial begin
    #1;
    #((steps.size() + 200) * 40);
    $display("Timeout: the run did not reach its end");
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== tests/robChecker.sv ====
// ----------------------------
// ROB checker
// Queue model of commit order,
// redirect target and table checks
// ----------------------------
`timescale 1ns/1ps

module robChecker (
  input  logic                               clk,
  input  logic                               arstN,
  input  robTypesPkg::allocReq_t             alloc,
  input  logic                               allocStrobe,
  input  logic                               allocReady,
  input  robTypesPkg::robTag_t               allocTag,
  input  robTypesPkg::cdbMsg_t               cdb,
  input  ctrlFlowPkg::branchRes_t            branch,
  input  robTypesPkg::commitMsg_t            commit,
  input  logic                               redirectValid,
  input  logic [31:0]                        redirectPc,
  input  logic [31:0]                        valueA,
  input  logic [31:0]                        valueB,
  input  logic                               readyA,
  input  logic                               readyB,
  input  logic                               busyA,
  input  logic                               busyB,
  input  robTypesPkg::robTag_t               tagA,
  input  robTypesPkg::robTag_t               tagB,
  input  logic [31:0]                        testName,  // Current table step
  input  logic [1:0]                         chkKind,   // 1 lookup, 2 status, 3 allocation
  input  logic [31:0]                        expA,
  input  logic [2:0]                         expB,
  output int                                 errCount
);

  logic [31:0] mVal [8];     // Modeled entry values
  logic [31:0] mTarget [8];
  logic mReady [8];
  logic mMisp [8];           // Resolved as mispredicted
  ctrlFlowPkg::instrClass_t mCls [8];
  logic [4:0] mDest [8];
  robTypesPkg::robTag_t order [$];  // Oldest first
  int errors = 0;

  assign errCount = errors;

  task automatic compare(input string what, input logic [31:0] expV, input logic [31:0] actV);
    if (expV !== actV) begin
      errors++;
      $display("error %0s %0s: expected %h, actual %h", testName, what, expV, actV);
    end
  endtask

  // Sample mid-cycle, inputs and outputs are settled
  always @(negedge clk) begin : observe
    robTypesPkg::robTag_t t;
    logic expRedir;
    if (arstN) begin
      expRedir = 1'b0;
      if (commit.valid) begin
        if (order.size() == 0) begin
          errors++;
          $display("%0s: commit while the model holds no entry", testName);
        end else begin
          t = order.pop_front();
          // Mispredicted branch or JALR at the head redirects
          expRedir = mMisp[t] &&
                     (mCls[t] inside {ctrlFlowPkg::clsBranch, ctrlFlowPkg::clsJalr});
          compare("commit tag", t, commit.info.tag);
          compare("commit class", mCls[t], commit.info.cls);
          compare("commit dest", mDest[t], commit.info.dest);
          compare("commit result", mVal[t], commit.info.result);
          // Stores and branches leave the register file alone
          compare("regWrite", !(mCls[t] inside {ctrlFlowPkg::clsStore, ctrlFlowPkg::clsBranch}),
                  commit.info.regWrite);
          compare("memWrite", mCls[t] == ctrlFlowPkg::clsStore, commit.info.memWrite);
          if (!mReady[t]) begin
            errors++;
            $display("%0s: commit of an entry that has no result yet", testName);
          end
          compare("redirectValid", expRedir, redirectValid);
          if (expRedir) compare("redirect pc", mTarget[t], redirectPc);
        end
      end else if (redirectValid) begin
        errors++;
        $display("%0s: redirect without a commit", testName);
      end
      if (allocStrobe && allocReady) begin  // Taken at the coming edge
        order.push_back(allocTag);
        mCls[allocTag]   = alloc.cls;
        mDest[allocTag]  = alloc.dest;
        mVal[allocTag]   = alloc.earlyResult;
        mReady[allocTag] = alloc.earlyReady;
        mMisp[allocTag]  = 1'b0;
      end
      if (cdb.valid) begin
        mVal[cdb.tag]   = cdb.result;
        mReady[cdb.tag] = 1'b1;
      end
      if (branch.valid) begin
        mTarget[branch.tag] = branch.target;
        mMisp[branch.tag]   = branch.mispredict;
      end
      if (expRedir) order.delete();  // Younger entries are gone
      case (chkKind)
        2'd1: begin
          compare("valueA", expA, valueA);
          compare("valueB", expA, valueB);
          compare("readyA", expB[0], readyA);
          compare("readyB", expB[0], readyB);
        end
        2'd2: begin
          compare("busyA", expA[0], busyA);
          compare("busyB", expA[0], busyB);
          if (expA[0]) compare("tagA", expB, tagA);
          if (expA[0]) compare("tagB", expB, tagB);
        end
        2'd3: begin
          compare("allocReady", expA[0], allocReady);
          if (expA[0]) compare("allocTag", expB, allocTag);
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/robSubsystem.sv ====
// ----------------------------
// ROB subsystem top level
// Pointers, commit FSM, entry
// storage and status table
// ----------------------------
`timescale 1ns/1ps

module robSubsystem #(
  parameter int DataWidth = robTypesPkg::dataWidth,
  parameter int RobDepth  = robTypesPkg::robDepth,
  parameter int RegCount  = robTypesPkg::regCount
) (
  input  logic                               clk,
  input  logic                               arstN,
  input  robTypesPkg::allocReq_t             alloc,
  input  logic                               allocStrobe,
  input  robTypesPkg::cdbMsg_t               cdb,
  input  ctrlFlowPkg::branchRes_t            branch,
  input  robTypesPkg::robTag_t               lookupTagA,
  input  robTypesPkg::robTag_t               lookupTagB,
  input  robTypesPkg::archReg_t              srcRegA,
  input  robTypesPkg::archReg_t              srcRegB,
  output logic                               allocReady,
  output robTypesPkg::robTag_t               allocTag,
  output robTypesPkg::commitMsg_t            commit,
  output logic                               redirectValid,
  output logic [ctrlFlowPkg::addrWidth-1:0]  redirectPc,
  output logic [DataWidth-1:0]               valueA,
  output logic [DataWidth-1:0]               valueB,
  output logic                               readyA,
  output logic                               readyB,
  output logic                               busyA,
  output logic                               busyB,
  output robTypesPkg::robTag_t               tagA,
  output robTypesPkg::robTag_t               tagB
);

  robTypesPkg::robTag_t head;
  robTypesPkg::robTag_t tail;
  robTypesPkg::commitInfo_t headCommit;
  logic [ctrlFlowPkg::addrWidth-1:0] headTarget;
  logic full, empty, push, commitFire, flush, inFlush;
  logic headReady, headMispredict, allocWrite, commitWrite;

  assign allocReady  = !full && !inFlush;
  assign push        = allocStrobe && allocReady;  // Dropped strobes are re-sent
  assign allocTag    = tail;
  assign allocWrite  = push && ctrlFlowPkg::writesReg(alloc.cls);
  assign commitWrite = commitFire && headCommit.regWrite;
  assign commit      = '{valid: commitFire, info: headCommit};

  robPointers #(.RobDepth(RobDepth)) pointers_i (
    .clk, .arstN, .push, .pop(commitFire), .flush, .head, .tail, .full, .empty
  );

  commitSequencer sequencer_i (
    .clk, .arstN, .empty, .headReady, .headMispredict, .headTarget,
    .commitFire, .flush, .redirectValid, .inFlush, .redirectPc
  );

  reorderBuffer #(.DataWidth(DataWidth), .RobDepth(RobDepth)) buffer_i (
    .clk, .arstN, .alloc, .push, .tail, .head, .cdb, .branch,
    .lookupTagA, .lookupTagB, .valueA, .valueB, .readyA, .readyB,
    .headReady, .headMispredict, .headTarget, .headCommit
  );

  renameStatus #(.RegCount(RegCount)) status_i (
    .clk, .arstN, .allocWrite, .allocDest(alloc.dest), .allocTag(tail),
    .commitWrite, .commitDest(headCommit.dest), .commitTag(head), .flush,
    .srcRegA, .srcRegB, .busyA, .busyB, .tagA, .tagB
  );

endmodule

// ==== rtl/renameStatus.sv ====
// ----------------------------
// Register status table
// Busy bit and youngest ROB tag
// per architectural register
// ----------------------------
`timescale 1ns/1ps

module renameStatus #(
  parameter int RegCount = robTypesPkg::regCount
) (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   allocWrite,  // Allocation writes a register
  input  robTypesPkg::archReg_t  allocDest,
  input  robTypesPkg::robTag_t   allocTag,
  input  logic                   commitWrite, // Commit writes a register
  input  robTypesPkg::archReg_t  commitDest,
  input  robTypesPkg::robTag_t   commitTag,
  input  logic                   flush,
  input  robTypesPkg::archReg_t  srcRegA,
  input  robTypesPkg::archReg_t  srcRegB,
  output logic                   busyA,
  output logic                   busyB,
  output robTypesPkg::robTag_t   tagA,
  output robTypesPkg::robTag_t   tagB
);

  logic [RegCount-1:0] busy;
  robTypesPkg::robTag_t tagTab [RegCount];  // Youngest pending producer
  logic allocSet;
  logic commitClr;

  assign allocSet  = allocWrite && (allocDest != '0);  // x0 never renamed
  // Clear only if no younger producer took the register over
  assign commitClr = commitWrite && busy[commitDest] && (tagTab[commitDest] == commitTag);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy <= '0;
    end else if (flush) begin
      busy <= '0;  // Wrong-path producers are gone
    end else begin
      if (commitClr) busy[commitDest] <= 1'b0;
      if (allocSet) busy[allocDest] <= 1'b1;  // Allocation wins on the same register
    end
  end

  always_ff @(posedge clk) begin
    if (allocSet) tagTab[allocDest] <= allocTag;
  end

  assign busyA = busy[srcRegA];
  assign busyB = busy[srcRegB];
  assign tagA  = tagTab[srcRegA];
  assign tagB  = tagTab[srcRegB];

endmodule

// ==== rtl/reorderBuffer.sv ====
// ----------------------------
// Reorder buffer storage
// Entry info, value, ready and
// control-flow arrays, head read
// and two operand lookup ports
// ----------------------------
`timescale 1ns/1ps

module reorderBuffer #(
  parameter int DataWidth = robTypesPkg::dataWidth,
  parameter int RobDepth  = robTypesPkg::robDepth
) (
  input  logic                               clk,
  input  logic                               arstN,
  input  robTypesPkg::allocReq_t             alloc,
  input  logic                               push,
  input  robTypesPkg::robTag_t               tail,
  input  robTypesPkg::robTag_t               head,
  input  robTypesPkg::cdbMsg_t               cdb,
  input  ctrlFlowPkg::branchRes_t            branch,
  input  robTypesPkg::robTag_t               lookupTagA,
  input  robTypesPkg::robTag_t               lookupTagB,
  output logic [DataWidth-1:0]               valueA,
  output logic [DataWidth-1:0]               valueB,
  output logic                               readyA,
  output logic                               readyB,
  output logic                               headReady,
  output logic                               headMispredict,
  output logic [ctrlFlowPkg::addrWidth-1:0]  headTarget,
  output robTypesPkg::commitInfo_t           headCommit
);

  // Payload arrays
  robTypesPkg::entryInfo_t infoArr [RobDepth];
  logic [DataWidth-1:0] valueArr [RobDepth];
  logic [ctrlFlowPkg::addrWidth-1:0] targetArr [RobDepth];

  // Control bits, cleared on reset
  logic [RobDepth-1:0] readyArr;
  logic [RobDepth-1:0] mispArr;

  robTypesPkg::entryInfo_t headInfo;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      readyArr <= '0;
      mispArr  <= '0;
    end else begin
      if (push) begin
        readyArr[tail] <= alloc.earlyReady;  // JAL and U-type are done at rename
        mispArr[tail]  <= 1'b0;
      end
      // Result write-back, independent of fullness
      if (cdb.valid) readyArr[cdb.tag] <= 1'b1;
      if (branch.valid) mispArr[branch.tag] <= branch.mispredict;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      infoArr[tail]   <= '{cls: alloc.cls, dest: alloc.dest};
      valueArr[tail]  <= alloc.earlyResult;
      // Fall-through PC until the branch unit resolves it
      targetArr[tail] <= alloc.pc + ctrlFlowPkg::addrWidth'(4);
    end
    if (cdb.valid) valueArr[cdb.tag] <= cdb.result;
    if (branch.valid) targetArr[branch.tag] <= branch.target;
  end

  // Head read, asynchronous
  assign headInfo   = infoArr[head];
  assign headReady  = readyArr[head];
  assign headTarget = targetArr[head];
  // Only branches and JALR can redirect
  assign headMispredict = mispArr[head] &&
                          (headInfo.cls inside {ctrlFlowPkg::clsBranch, ctrlFlowPkg::clsJalr});

  always_comb begin
    headCommit.tag      = head;
    headCommit.cls      = headInfo.cls;
    headCommit.dest     = headInfo.dest;
    headCommit.result   = valueArr[head];
    headCommit.regWrite = ctrlFlowPkg::writesReg(headInfo.cls);
    headCommit.memWrite = ctrlFlowPkg::writesMem(headInfo.cls);
  end

  // Operand lookups, no bypass from a same-cycle broadcast
  assign valueA = valueArr[lookupTagA];
  assign readyA = readyArr[lookupTagA];
  assign valueB = valueArr[lookupTagB];
  assign readyB = readyArr[lookupTagB];

  // Execution units only broadcast tags that were allocated earlier
  assert property (@(posedge clk) disable iff (!arstN)
    !(push && cdb.valid && cdb.tag == tail))
    else $error("CDB broadcast to the entry being allocated");

endmodule

// ==== rtl/commitSequencer.sv ====
// ----------------------------
// Commit sequencer
// Commit FSM, commit pop, flush
// and PC redirect generation
// ----------------------------
`timescale 1ns/1ps

module commitSequencer (
  input  logic                                clk,
  input  logic                                arstN,
  input  logic                                empty,
  input  logic                                headReady,       // Head result available
  input  logic                                headMispredict,  // Head is a wrong-path redirect
  input  logic [ctrlFlowPkg::addrWidth-1:0]   headTarget,
  output logic                                commitFire,
  output logic                                flush,
  output logic                                redirectValid,
  output logic                                inFlush,
  output logic [ctrlFlowPkg::addrWidth-1:0]   redirectPc
);

  ctrlFlowPkg::commitState_t state;
  ctrlFlowPkg::commitState_t stateNext;

  // Commit in stRun only, never during the flush cycle
  assign commitFire = (state == ctrlFlowPkg::stRun) && !empty && headReady;
  assign flush      = commitFire && headMispredict;
  assign redirectValid = flush;        // Same cycle as the commit
  assign redirectPc    = headTarget;   // Resolved target of the head
  assign inFlush    = (state == ctrlFlowPkg::stFlush);

  always_comb begin
    stateNext = state;
    unique case (state)
      ctrlFlowPkg::stIdle: begin
        if (!empty) stateNext = ctrlFlowPkg::stRun;
      end
      ctrlFlowPkg::stRun: begin
        if (flush) begin
          stateNext = ctrlFlowPkg::stFlush;
        end else if (empty) begin
          stateNext = ctrlFlowPkg::stIdle;  // Drained
        end
      end
      ctrlFlowPkg::stFlush: begin
        stateNext = ctrlFlowPkg::stIdle;  // Buffer is empty after a flush
      end
      default: stateNext = ctrlFlowPkg::stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= ctrlFlowPkg::stIdle;
    end else begin
      state <= stateNext;
    end
  end

  // A redirect retires the head, then one quiet flush cycle on an empty buffer
  assert property (@(posedge clk) disable iff (!arstN)
    redirectValid |-> commitFire ##1 (inFlush && empty && !commitFire))
    else $error("redirect not paired with commit and flush cycle");

endmodule

// ==== rtl/robPointers.sv ====
// ----------------------------
// ROB head/tail pointers
// Wrapping counters, occupancy count,
// full and empty flags
// ----------------------------
`timescale 1ns/1ps

module robPointers #(
  parameter int RobDepth = robTypesPkg::robDepth
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  push,   // Allocate at tail
  input  logic                  pop,    // Commit at head
  input  logic                  flush,  // Discard everything younger than head
  output robTypesPkg::robTag_t  head,
  output robTypesPkg::robTag_t  tail,
  output logic                  full,
  output logic                  empty
);

  localparam int CntBits = $clog2(RobDepth + 1);

  logic [CntBits-1:0] count;  // Occupancy, 0..RobDepth
  robTypesPkg::robTag_t headNext;
  robTypesPkg::robTag_t tailNext;

  // Wrap at RobDepth, not only at the tag width
  assign headNext = (head == robTypesPkg::robTag_t'(RobDepth - 1)) ? '0 : head + 1'b1;
  assign tailNext = (tail == robTypesPkg::robTag_t'(RobDepth - 1)) ? '0 : tail + 1'b1;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= headNext;  // Mispredicted entry retires
      tail  <= headNext;  // Younger entries dropped
      count <= '0;
    end else begin
      if (pop) head <= headNext;
      if (push) tail <= tailNext;
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither, count holds
      endcase
    end
  end

  assign full  = (count == CntBits'(RobDepth));  // All entries usable
  assign empty = (count == '0);

  // Allocation gating lives at the top level
  assert property (@(posedge clk) disable iff (!arstN) !(push && full))
    else $error("push while ROB full");
  // Commit gating lives in the sequencer
  assert property (@(posedge clk) disable iff (!arstN) !(pop && empty))
    else $error("pop while ROB empty");

endmodule

// ==== rtl/robTypesPkg.sv ====
// ----------------------------
// ROB sizes and types
// Tag and register index types,
// allocation, CDB, entry and
// commit message structs
// ----------------------------

package robTypesPkg;

  // Defaults only, the top level carries the real values
  localparam int dataWidth = 32;
  localparam int regCount = 32;
  localparam int robDepth = 1 << ctrlFlowPkg::tagBits;

  typedef logic [ctrlFlowPkg::tagBits-1:0] robTag_t;  // Entry index
  typedef logic [$clog2(regCount)-1:0] archReg_t;     // x0..x31

  // Allocation request from rename, 73 bits
  typedef struct packed {
    ctrlFlowPkg::instrClass_t cls;
    archReg_t dest;
    logic [dataWidth-1:0] earlyResult;  // JAL link value or U-type result
    logic earlyReady;                   // Entry is born ready
    logic [ctrlFlowPkg::addrWidth-1:0] pc;
  } allocReq_t;

  // Common data bus broadcast, 36 bits
  typedef struct packed {
    logic valid;
    robTag_t tag;
    logic [dataWidth-1:0] result;
  } cdbMsg_t;

  // Per-entry instruction info
  typedef struct packed {
    ctrlFlowPkg::instrClass_t cls;
    archReg_t dest;
  } entryInfo_t;

  // Head entry contents presented at commit
  typedef struct packed {
    robTag_t tag;
    ctrlFlowPkg::instrClass_t cls;
    archReg_t dest;
    logic [dataWidth-1:0] result;
    logic regWrite;
    logic memWrite;
  } commitInfo_t;

  typedef struct packed {
    logic valid;        // Commit happens this cycle
    commitInfo_t info;
  } commitMsg_t;

endpackage

// ==== rtl/ctrlFlowPkg.sv ====
// ----------------------------
// Control-flow definitions
// Instruction class, commit FSM states,
// branch resolution message and the
// class to write-flag decode
// ----------------------------

package ctrlFlowPkg;

  localparam int addrWidth = 32;  // PC and target width
  localparam int tagBits = 3;     // ROB tag width, 8 entries

  // Instruction class as seen by the ROB
  typedef enum logic [2:0] {
    clsAlu,
    clsLoad,
    clsStore,
    clsBranch,
    clsJal,
    clsJalr
  } instrClass_t;

  typedef enum logic [1:0] {
    stIdle,   // Nothing to commit
    stRun,    // Entries present
    stFlush   // One cycle after a redirect
  } commitState_t;

  // Branch resolution from the branch unit, 37 bits
  typedef struct packed {
    logic valid;
    logic [tagBits-1:0] tag;
    logic mispredict;
    logic [addrWidth-1:0] target;
  } branchRes_t;

  // Stores and branches leave the register file alone
  function automatic logic writesReg(instrClass_t cls);
    return !(cls inside {clsStore, clsBranch});
  endfunction

  function automatic logic writesMem(instrClass_t cls);
    return cls == clsStore;
  endfunction

endpackage
